// ==== design/ln_pkg.sv ====
package ln_pkg;

    // lanes per beat, must stay a power of two
    localparam int LANE_NUM = 8;
    localparam int LANE_W = 8;
    localparam int ACC_W = 32;

    typedef logic signed [LANE_W-1:0] lane_t;
    typedef logic signed [ACC_W-1:0] acc_t;

    // lane 0 sits in the low bits
    typedef lane_t [LANE_NUM-1:0] beat_t;

    typedef struct packed {
        logic valid;
        logic last;
        beat_t data;
    } ln_stream_t;

    typedef enum logic [1:0] {
        ST_LOAD,
        ST_REDUCE,
        ST_CENTER
    } ln_state_t;

endpackage

// ==== design/ln_adder_tree.sv ====
`timescale 1ns/1ps

module ln_adder_tree (
    input  logic          clk,
    input  logic          rstn,
    input  ln_pkg::beat_t in_data,
    input  logic          in_valid,
    output ln_pkg::acc_t  sum,
    output logic          sum_valid
);

    // one register per level
    localparam int TREE_LAT = $clog2(ln_pkg::LANE_NUM);

    for (genvar k = 0; k < TREE_LAT; k++) begin : gen_lvl
        localparam int NODES = ln_pkg::LANE_NUM >> (k + 1);

        ln_pkg::acc_t node [NODES];
        logic         vld;

        for (genvar j = 0; j < NODES; j++) begin : gen_add
            if (k == 0) begin : gen_leaf
                // lanes are sign-extended by the signed context
                always_ff @(posedge clk) begin
                    node[j] <= $signed(in_data[2*j]) + $signed(in_data[2*j+1]);
                end
            end else begin : gen_inner
                always_ff @(posedge clk) begin
                    node[j] <= gen_lvl[k-1].node[2*j] + gen_lvl[k-1].node[2*j+1];
                end
            end
        end

        if (k == 0) begin : gen_vld_first
            always_ff @(posedge clk or negedge rstn) begin
                if (!rstn) begin
                    vld <= 1'b0;
                end else begin
                    vld <= in_valid;
                end
            end
        end else begin : gen_vld_next
            always_ff @(posedge clk or negedge rstn) begin
                if (!rstn) begin
                    vld <= 1'b0;
                end else begin
                    vld <= gen_lvl[k-1].vld;
                end
            end
        end
    end

    assign sum = gen_lvl[TREE_LAT-1].node[0];
    assign sum_valid = gen_lvl[TREE_LAT-1].vld;

endmodule

// ==== design/ln_beat_buffer.sv ====
`timescale 1ns/1ps

module ln_beat_buffer #(
    parameter int BEATS = 4
) (
    input  logic          clk,
    input  logic          rstn,
    input  logic          wr_en,
    input  ln_pkg::beat_t wr_data,
    input  logic          rd_en,
    output ln_pkg::beat_t rd_data,
    output logic          rd_valid,
    output logic          empty
);

    localparam int PTR_W = $clog2(BEATS);
    localparam int CNT_W = $clog2(BEATS + 1);

    ln_pkg::beat_t mem [BEATS];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic wr_ok;
    logic rd_ok;

    assign empty = (count == '0);
    // extra writes while full are dropped
    assign wr_ok = wr_en && (count != CNT_W'(BEATS));
    assign rd_ok = rd_en && !empty;

    always_ff @(posedge clk) begin
        if (wr_ok) begin
            mem[wr_ptr] <= wr_data;
        end
        if (rd_ok) begin
            rd_data <= mem[rd_ptr];
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
            rd_valid <= 1'b0;
        end else begin
            rd_valid <= rd_ok;
            if (wr_ok) begin
                wr_ptr <= (wr_ptr == PTR_W'(BEATS - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (rd_ok) begin
                rd_ptr <= (rd_ptr == PTR_W'(BEATS - 1)) ? '0 : rd_ptr + 1'b1;
            end
            if (wr_ok && !rd_ok) begin
                count <= count + 1'b1;
            end else if (rd_ok && !wr_ok) begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

// ==== design/ln_mean_unit.sv ====
`timescale 1ns/1ps

module ln_mean_unit #(
    parameter int BEATS = 4
) (
    input  logic          clk,
    input  logic          rstn,
    input  ln_pkg::acc_t  sum,
    input  logic          sum_valid,
    output ln_pkg::lane_t mean,
    output logic          mean_valid
);

    // divide by element count, BEATS is a power of two
    localparam int MEAN_SHIFT = $clog2(ln_pkg::LANE_NUM * BEATS);
    localparam int CNT_W = $clog2(BEATS);

    ln_pkg::acc_t total;
    ln_pkg::acc_t total_next;
    ln_pkg::acc_t shifted;
    logic [CNT_W-1:0] cnt;
    logic final_beat;

    assign total_next = total + sum;
    assign shifted = total_next >>> MEAN_SHIFT;
    assign final_beat = sum_valid && (cnt == CNT_W'(BEATS - 1));

    always_ff @(posedge clk) begin
        if (final_beat) begin
            mean <= shifted[ln_pkg::LANE_W-1:0];
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            total <= '0;
            cnt <= '0;
            mean_valid <= 1'b0;
        end else begin
            mean_valid <= final_beat;
            if (final_beat) begin
                total <= '0;
                cnt <= '0;
            end else if (sum_valid) begin
                total <= total_next;
                cnt <= cnt + 1'b1;
            end
        end
    end

endmodule

// ==== design/ln_center_unit.sv ====
`timescale 1ns/1ps

module ln_center_unit #(
    parameter int BEATS = 4
) (
    input  logic               clk,
    input  logic               rstn,
    input  ln_pkg::lane_t      mean,
    input  ln_pkg::beat_t      rd_data,
    input  logic               rd_valid,
    output ln_pkg::ln_stream_t out_stream,
    output ln_pkg::acc_t       var_data,
    output logic               var_valid
);

    localparam int MEAN_SHIFT = $clog2(ln_pkg::LANE_NUM * BEATS);
    localparam int CNT_W = $clog2(BEATS);

    logic signed [ln_pkg::LANE_W:0] diff [ln_pkg::LANE_NUM];
    ln_pkg::beat_t sat;
    ln_pkg::beat_t out_data;
    logic out_valid;
    logic out_last;
    logic [CNT_W-1:0] cnt;
    ln_pkg::acc_t beat_sq;
    ln_pkg::acc_t sq_acc;
    ln_pkg::acc_t sq_total;

    // 9-bit difference, then clamp to int8
    always_comb begin
        for (int i = 0; i < ln_pkg::LANE_NUM; i++) begin
            diff[i] = $signed(rd_data[i]) - $signed(mean);
            if (diff[i] > 9'sd127) begin
                sat[i] = 8'sd127;
            end else if (diff[i] < -9'sd128) begin
                sat[i] = -8'sd128;
            end else begin
                sat[i] = diff[i][ln_pkg::LANE_W-1:0];
            end
        end
    end

    // squares taken from the registered output beat
    always_comb begin
        beat_sq = '0;
        for (int i = 0; i < ln_pkg::LANE_NUM; i++) begin
            beat_sq = beat_sq + $signed(out_data[i]) * $signed(out_data[i]);
        end
    end

    assign sq_total = sq_acc + beat_sq;
    assign out_stream = '{valid: out_valid, last: out_last, data: out_data};

    always_ff @(posedge clk) begin
        out_data <= sat;
        if (out_valid && out_last) begin
            var_data <= sq_total >>> MEAN_SHIFT;
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            out_valid <= 1'b0;
            out_last <= 1'b0;
            cnt <= '0;
            sq_acc <= '0;
            var_valid <= 1'b0;
        end else begin
            out_valid <= rd_valid;
            out_last <= rd_valid && (cnt == CNT_W'(BEATS - 1));
            var_valid <= out_valid && out_last;
            if (rd_valid) begin
                cnt <= (cnt == CNT_W'(BEATS - 1)) ? '0 : cnt + 1'b1;
            end
            if (out_valid) begin
                sq_acc <= out_last ? '0 : sq_total;
            end
        end
    end

endmodule

// ==== design/ln_control.sv ====
`timescale 1ns/1ps

module ln_control #(
    parameter int BEATS = 4
) (
    input  logic clk,
    input  logic rstn,
    input  logic in_valid,
    output logic in_ready,
    output logic buf_wr,
    input  logic mean_valid,
    input  logic buf_empty,
    output logic buf_rd,
    input  logic var_valid
);

    localparam int CNT_W = $clog2(BEATS);

    ln_pkg::ln_state_t state;
    ln_pkg::ln_state_t state_next;
    logic [CNT_W-1:0] load_cnt;
    logic take;

    assign in_ready = (state == ln_pkg::ST_LOAD);
    assign take = in_valid && in_ready;
    // one take feeds both the buffer and the tree
    assign buf_wr = take;
    assign buf_rd = (state == ln_pkg::ST_CENTER) && !buf_empty;

    always_comb begin
        state_next = state;
        case (state)
            ln_pkg::ST_LOAD: begin
                if (take && (load_cnt == CNT_W'(BEATS - 1))) begin
                    state_next = ln_pkg::ST_REDUCE;
                end
            end
            ln_pkg::ST_REDUCE: begin
                if (mean_valid) begin
                    state_next = ln_pkg::ST_CENTER;
                end
            end
            ln_pkg::ST_CENTER: begin
                if (var_valid) begin
                    state_next = ln_pkg::ST_LOAD;
                end
            end
            default: begin
                state_next = ln_pkg::ST_LOAD;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state <= ln_pkg::ST_LOAD;
            load_cnt <= '0;
        end else begin
            state <= state_next;
            if (take) begin
                load_cnt <= (load_cnt == CNT_W'(BEATS - 1)) ? '0 : load_cnt + 1'b1;
            end
        end
    end

endmodule

// ==== design/layer_stats_top.sv ====
`timescale 1ns/1ps

module layer_stats_top #(
    parameter int BEATS = 4
) (
    input  logic               clk,
    input  logic               rstn,
    input  ln_pkg::beat_t      in_beat,
    input  logic               in_valid,
    output logic               in_ready,
    output ln_pkg::ln_stream_t out_stream,
    output ln_pkg::acc_t       var_data,
    output logic               var_valid
);

    logic          take;
    logic          buf_rd;
    logic          buf_empty;
    ln_pkg::beat_t rd_data;
    logic          rd_valid;
    ln_pkg::acc_t  tree_sum;
    logic          tree_valid;
    ln_pkg::lane_t mean;
    logic          mean_valid;

    ln_control #(
        .BEATS(BEATS)
    ) ln_control_inst (
        .clk(clk),
        .rstn(rstn),
        .in_valid(in_valid),
        .in_ready(in_ready),
        .buf_wr(take),
        .mean_valid(mean_valid),
        .buf_empty(buf_empty),
        .buf_rd(buf_rd),
        .var_valid(var_valid)
    );

    ln_adder_tree ln_adder_tree_inst (
        .clk(clk),
        .rstn(rstn),
        .in_data(in_beat),
        .in_valid(take),
        .sum(tree_sum),
        .sum_valid(tree_valid)
    );

    ln_beat_buffer #(
        .BEATS(BEATS)
    ) ln_beat_buffer_inst (
        .clk(clk),
        .rstn(rstn),
        .wr_en(take),
        .wr_data(in_beat),
        .rd_en(buf_rd),
        .rd_data(rd_data),
        .rd_valid(rd_valid),
        .empty(buf_empty)
    );

    ln_mean_unit #(
        .BEATS(BEATS)
    ) ln_mean_unit_inst (
        .clk(clk),
        .rstn(rstn),
        .sum(tree_sum),
        .sum_valid(tree_valid),
        .mean(mean),
        .mean_valid(mean_valid)
    );

    ln_center_unit #(
        .BEATS(BEATS)
    ) ln_center_unit_inst (
        .clk(clk),
        .rstn(rstn),
        .mean(mean),
        .rd_data(rd_data),
        .rd_valid(rd_valid),
        .out_stream(out_stream),
        .var_data(var_data),
        .var_valid(var_valid)
    );

endmodule

// ==== testbench/layer_stats_chk.sv ====
`timescale 1ns/1ps

module layer_stats_chk #(
    parameter int BEATS = 4
) (
    input logic               clk,
    input logic               rstn,
    input logic               in_ready,
    input ln_pkg::ln_stream_t out_stream,
    input logic               var_valid
);

    localparam int RUN_W = $clog2(BEATS + 1) + 1;

    logic [RUN_W-1:0] run_len;

    // output beats seen so far in the current run, saturating
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            run_len <= '0;
        end else if (!out_stream.valid) begin
            run_len <= '0;
        end else if (int'(run_len) <= BEATS) begin
            run_len <= run_len + 1'b1;
        end
    end

    var_after_last: assert property (@(posedge clk) disable iff (!rstn)
        (out_stream.valid && out_stream.last) |=> var_valid)
        else $error("var_valid did not follow the last output beat by one cycle");

    var_only_after_last: assert property (@(posedge clk) disable iff (!rstn)
        var_valid |-> $past(out_stream.valid && out_stream.last))
        else $error("var_valid came without a last output beat in the cycle before");

    no_ready_while_out: assert property (@(posedge clk) disable iff (!rstn)
        out_stream.valid |-> !in_ready)
        else $error("in_ready was high while an output beat was valid");

    beat_run_limit: assert property (@(posedge clk) disable iff (!rstn)
        out_stream.valid |-> (int'(run_len) < BEATS))
        else $error("output valid stayed high for more beats than one vector holds");

endmodule

bind layer_stats_top layer_stats_chk #(
    .BEATS(BEATS)
) layer_stats_chk_inst (
    .clk(clk),
    .rstn(rstn),
    .in_ready(in_ready),
    .out_stream(out_stream),
    .var_valid(var_valid)
);

// ==== testbench/tb_layer_stats.sv ====
`timescale 1ns/1ps

module tb_layer_stats;

    localparam int BEATS = 4;
    localparam int LANE_NUM = ln_pkg::LANE_NUM;
    localparam int MEAN_SHIFT = $clog2(LANE_NUM * BEATS);
    localparam int TIMEOUT = 50;

    logic clk;
    logic rstn;
    ln_pkg::beat_t in_beat;
    logic in_valid;
    logic in_ready;
    ln_pkg::ln_stream_t out_stream;
    ln_pkg::acc_t var_data;
    logic var_valid;

    logic [31:0] rng_state;
    logic junk_mode;
    int vec_lanes [BEATS][LANE_NUM];
    int exp_center [BEATS][LANE_NUM];
    int exp_var;

    layer_stats_top #(
        .BEATS(BEATS)
    ) layer_stats_top_inst (
        .clk(clk),
        .rstn(rstn),
        .in_beat(in_beat),
        .in_valid(in_valid),
        .in_ready(in_ready),
        .out_stream(out_stream),
        .var_data(var_data),
        .var_valid(var_valid)
    );

    always #20 clk = ~clk;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic stop_with_failure();
        $display("Simulation failed");
        $fatal(1, "testbench stopped");
    endtask

    task automatic check_value(input string name, input int expected, input int actual);
        assert (expected == actual) else begin
            $display("error at %0t ns: %s expected %0d actual %0d", $time, name, expected,
                     actual);
            stop_with_failure();
        end
    endtask

    task automatic report_timeout(input string what);
        $display("timeout at %0t ns: %s", $time, what);
        stop_with_failure();
    endtask

    // step to the drive point, junk lanes go out while the unit is busy
    task automatic next_cycle();
        @(posedge clk);
        #2;
        if (junk_mode) begin
            for (int i = 0; i < LANE_NUM; i++) begin
                rng_state = xorshift32(rng_state);
                in_beat[i] = rng_state[7:0];
            end
        end
    endtask

    task automatic fill_random();
        for (int b = 0; b < BEATS; b++) begin
            for (int i = 0; i < LANE_NUM; i++) begin
                rng_state = xorshift32(rng_state);
                vec_lanes[b][i] = $signed(rng_state[7:0]);
            end
        end
    endtask

    // every fourth lane takes the other extreme
    task automatic fill_extreme(input logic high_major);
        for (int b = 0; b < BEATS; b++) begin
            for (int i = 0; i < LANE_NUM; i++) begin
                if (((b * LANE_NUM + i) % 4) == 0) begin
                    vec_lanes[b][i] = high_major ? -128 : 127;
                end else begin
                    vec_lanes[b][i] = high_major ? 127 : -128;
                end
            end
        end
    endtask

    // floor mean, clamped centered lanes, shifted sum of squares
    task automatic compute_expected();
        int total;
        int mean;
        int d;
        int sq;
        total = 0;
        sq = 0;
        for (int b = 0; b < BEATS; b++) begin
            for (int i = 0; i < LANE_NUM; i++) begin
                total += vec_lanes[b][i];
            end
        end
        mean = total >>> MEAN_SHIFT;
        for (int b = 0; b < BEATS; b++) begin
            for (int i = 0; i < LANE_NUM; i++) begin
                d = vec_lanes[b][i] - mean;
                if (d > 127) begin
                    d = 127;
                end else if (d < -128) begin
                    d = -128;
                end
                exp_center[b][i] = d;
                sq += d * d;
            end
        end
        exp_var = sq >>> MEAN_SHIFT;
    endtask

    task automatic send_beat(input int b);
        int waited;
        logic taken;
        for (int i = 0; i < LANE_NUM; i++) begin
            in_beat[i] = ln_pkg::lane_t'(vec_lanes[b][i]);
        end
        in_valid = 1'b1;
        waited = 0;
        taken = 1'b0;
        while (!taken) begin
            @(negedge clk);
            taken = in_ready;
            if (!taken) begin
                waited++;
                if (waited > TIMEOUT) begin
                    report_timeout("in_ready stayed low while loading a vector");
                end
            end
            @(posedge clk);
            #2;
        end
    endtask

    task automatic run_vector(input logic with_junk);
        int got;
        int waited;
        compute_expected();
        for (int b = 0; b < BEATS; b++) begin
            send_beat(b);
        end
        in_valid = with_junk;
        junk_mode = with_junk;
        got = 0;
        waited = 0;
        while (got < BEATS) begin
            @(negedge clk);
            if (out_stream.valid) begin
                for (int i = 0; i < LANE_NUM; i++) begin
                    check_value($sformatf("out_stream.data[%0d] beat %0d", i, got),
                                exp_center[got][i], int'(out_stream.data[i]));
                end
                check_value("out_stream.last", int'(got == BEATS - 1), int'(out_stream.last));
                got++;
            end else begin
                waited++;
                if (waited > TIMEOUT) begin
                    report_timeout("output beats of a vector did not arrive");
                end
            end
            next_cycle();
        end
        waited = 0;
        @(negedge clk);
        while (!var_valid) begin
            check_value("out_stream.valid", 0, int'(out_stream.valid));
            waited++;
            if (waited > TIMEOUT) begin
                report_timeout("var_valid did not rise after the last output beat");
            end
            next_cycle();
            @(negedge clk);
        end
        check_value("var_data", exp_var, int'(var_data));
        next_cycle();
        in_valid = 1'b0;
        junk_mode = 1'b0;
        @(negedge clk);
        check_value("in_ready", 1, int'(in_ready));
        next_cycle();
    endtask

    initial begin
        clk = 1'b0;
        rstn = 1'b0;
        in_valid = 1'b0;
        in_beat = '0;
        junk_mode = 1'b0;
        rng_state = 32'd21;
        repeat (3) @(posedge clk);
        #2;
        rstn = 1'b1;
        // idle unit after reset
        repeat (4) begin
            @(negedge clk);
            check_value("in_ready", 1, int'(in_ready));
            check_value("out_stream.valid", 0, int'(out_stream.valid));
            check_value("var_valid", 0, int'(var_valid));
        end
        next_cycle();
        for (int n = 0; n < 6; n++) begin
            fill_random();
            run_vector(n >= 4);
        end
        fill_extreme(1'b1);
        run_vector(1'b0);
        fill_extreme(1'b0);
        run_vector(1'b1);
        fill_random();
        run_vector(1'b0);
        $display("Simulation passed");
        $finish;
    end

endmodule

// ==== flist.f ====
design/ln_pkg.sv
design/ln_adder_tree.sv
design/ln_beat_buffer.sv
design/ln_mean_unit.sv
design/ln_center_unit.sv
design/ln_control.sv
design/layer_stats_top.sv
testbench/layer_stats_chk.sv
testbench/tb_layer_stats.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal --top-module tb_layer_stats \
    -f flist.f --Mdir obj_dir -o tb_layer_stats
out=$(./obj_dir/tb_layer_stats 2>&1) || true
echo "$out"
if echo "$out" | grep -q "^Simulation passed$"; then
    exit 0
fi
echo "run.sh: simulation did not report success" >&2
exit 1
